// ==== logic/mips_pc_pkg.sv ====
package mips_pc_pkg;

    // One machine word, used for byte addresses and register values.
    typedef logic [31:0] addr_t;

    typedef enum logic [1:0] {
        FETCH = 2'd0,
        EXEC1 = 2'd1,
        EXEC2 = 2'd2
    } cycle_state_e;

    typedef enum logic [3:0] {
        NONE   = 4'd0,
        J      = 4'd1,
        JAL    = 4'd2,
        JR     = 4'd3,
        JALR   = 4'd4,
        BEQ    = 4'd5,
        BNE    = 4'd6,
        BLEZ   = 4'd7,
        BGTZ   = 4'd8,
        BLTZ   = 4'd9,
        BGEZ   = 4'd10,
        BLTZAL = 4'd11,
        BGEZAL = 4'd12
    } branch_kind_e;

    typedef struct packed {
        branch_kind_e kind;
        logic [15:0]  imm16;     // Branch offset in words.
        logic [25:0]  index26;   // Jump index.
        logic [4:0]   link_dest;
    } branch_ctrl_t;

    typedef struct packed {
        logic  taken;
        addr_t target;
        logic  link;
    } resolve_t;

    localparam logic [4:0] LINK_REG = 5'd31;

    localparam addr_t DEFAULT_RESET_VECTOR = 32'hBFC0_0000;

endpackage

// ==== logic/branch_decode.sv ====
`timescale 1ns/1ps

module branch_decode (
    input  logic [31:0]               instr,
    output mips_pc_pkg::branch_ctrl_t ctrl
);

    localparam logic [5:0] OP_SPECIAL = 6'd0;
    localparam logic [5:0] OP_REGIMM  = 6'd1;
    localparam logic [5:0] OP_J       = 6'd2;
    localparam logic [5:0] OP_JAL     = 6'd3;
    localparam logic [5:0] OP_BEQ     = 6'd4;
    localparam logic [5:0] OP_BNE     = 6'd5;
    localparam logic [5:0] OP_BLEZ    = 6'd6;
    localparam logic [5:0] OP_BGTZ    = 6'd7;

    localparam logic [5:0] FN_JR      = 6'd8;
    localparam logic [5:0] FN_JALR    = 6'd9;

    localparam logic [4:0] RT_BLTZ    = 5'd0;
    localparam logic [4:0] RT_BGEZ    = 5'd1;
    localparam logic [4:0] RT_BLTZAL  = 5'd16;
    localparam logic [4:0] RT_BGEZAL  = 5'd17;

    logic [5:0] opcode;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [5:0] funct;
    mips_pc_pkg::branch_kind_e kind;

    assign opcode = instr[31:26];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign funct  = instr[5:0];

    always_comb begin
        kind = mips_pc_pkg::NONE;
        case (opcode)
            OP_SPECIAL: begin
                if (funct == FN_JR) kind = mips_pc_pkg::JR;
                else if (funct == FN_JALR) kind = mips_pc_pkg::JALR;
            end
            OP_REGIMM: begin
                case (rt)   // Condition lives in rt field.
                    RT_BLTZ:   kind = mips_pc_pkg::BLTZ;
                    RT_BGEZ:   kind = mips_pc_pkg::BGEZ;
                    RT_BLTZAL: kind = mips_pc_pkg::BLTZAL;
                    RT_BGEZAL: kind = mips_pc_pkg::BGEZAL;
                    default:   kind = mips_pc_pkg::NONE;
                endcase
            end
            OP_J:    kind = mips_pc_pkg::J;
            OP_JAL:  kind = mips_pc_pkg::JAL;
            OP_BEQ:  kind = mips_pc_pkg::BEQ;
            OP_BNE:  kind = mips_pc_pkg::BNE;
            OP_BLEZ: kind = mips_pc_pkg::BLEZ;
            OP_BGTZ: kind = mips_pc_pkg::BGTZ;
            default: kind = mips_pc_pkg::NONE;
        endcase
    end

    always_comb begin
        ctrl.kind    = kind;
        ctrl.imm16   = instr[15:0];
        ctrl.index26 = instr[25:0];
        case (kind)
            mips_pc_pkg::JALR:   ctrl.link_dest = rd;
            mips_pc_pkg::JAL,
            mips_pc_pkg::BLTZAL,
            mips_pc_pkg::BGEZAL: ctrl.link_dest = mips_pc_pkg::LINK_REG;
            default:             ctrl.link_dest = 5'd0;   // No link.
        endcase
    end

endmodule

// ==== logic/branch_resolve.sv ====
`timescale 1ns/1ps

module branch_resolve (
    input  mips_pc_pkg::branch_ctrl_t ctrl,
    input  mips_pc_pkg::addr_t        r_s,
    input  mips_pc_pkg::addr_t        r_t,
    input  mips_pc_pkg::addr_t        pc_next,
    output mips_pc_pkg::resolve_t     res
);

    mips_pc_pkg::addr_t offset;
    mips_pc_pkg::addr_t branch_target;
    mips_pc_pkg::addr_t jump_target;
    logic               rs_neg;
    logic               rs_zero;
    logic               rs_eq_rt;

    // Relative to the delay-slot address.
    assign offset        = {{14{ctrl.imm16[15]}}, ctrl.imm16, 2'b00};
    assign branch_target = pc_next + offset;
    assign jump_target   = {pc_next[31:28], ctrl.index26, 2'b00};

    assign rs_neg   = $signed(r_s) < 0;
    assign rs_zero  = r_s == '0;
    assign rs_eq_rt = r_s == r_t;

    always_comb begin
        res.taken  = 1'b0;
        res.target = branch_target;
        res.link   = 1'b0;
        case (ctrl.kind)
            mips_pc_pkg::J: begin
                res.taken  = 1'b1;
                res.target = jump_target;
            end
            mips_pc_pkg::JAL: begin
                res.taken  = 1'b1;
                res.target = jump_target;
                res.link   = 1'b1;
            end
            mips_pc_pkg::JR: begin
                res.taken  = 1'b1;
                res.target = r_s;
            end
            mips_pc_pkg::JALR: begin
                res.taken  = 1'b1;
                res.target = r_s;
                res.link   = 1'b1;
            end
            mips_pc_pkg::BEQ:  res.taken = rs_eq_rt;
            mips_pc_pkg::BNE:  res.taken = !rs_eq_rt;
            mips_pc_pkg::BLEZ: res.taken = rs_neg || rs_zero;
            mips_pc_pkg::BGTZ: res.taken = !rs_neg && !rs_zero;
            mips_pc_pkg::BLTZ: res.taken = rs_neg;
            mips_pc_pkg::BGEZ: res.taken = !rs_neg;
            mips_pc_pkg::BLTZAL: begin
                res.taken = rs_neg;
                res.link  = 1'b1;   // Links even when not taken.
            end
            mips_pc_pkg::BGEZAL: begin
                res.taken = !rs_neg;
                res.link  = 1'b1;
            end
            default: begin
                res.taken = 1'b0;
                res.link  = 1'b0;
            end
        endcase
    end

endmodule

// ==== logic/pc_sequencer.sv ====
`timescale 1ns/1ps

module pc_sequencer #(
    parameter mips_pc_pkg::addr_t RESET_VECTOR = mips_pc_pkg::DEFAULT_RESET_VECTOR
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      stall,
    input  mips_pc_pkg::resolve_t     res,
    input  logic [4:0]                link_dest,
    output mips_pc_pkg::cycle_state_e state,
    output mips_pc_pkg::addr_t        pc,
    output mips_pc_pkg::addr_t        pc_next,
    output logic                      active,
    output logic                      link_write,
    output mips_pc_pkg::addr_t        link_data,
    output logic [4:0]                link_dest_out
);

    logic halt;
    logic advance;
    logic exec2_edge;

    assign halt       = pc == '0;
    assign advance    = !stall && !halt;
    assign exec2_edge = advance && state == mips_pc_pkg::EXEC2;

    // Phase machine.
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mips_pc_pkg::FETCH;
        end else if (halt) begin
            state <= mips_pc_pkg::FETCH;   // Parked until reset.
        end else if (advance) begin
            case (state)
                mips_pc_pkg::FETCH: state <= mips_pc_pkg::EXEC1;
                mips_pc_pkg::EXEC1: state <= mips_pc_pkg::EXEC2;
                mips_pc_pkg::EXEC2: state <= mips_pc_pkg::FETCH;
                default:            state <= mips_pc_pkg::FETCH;
            endcase
        end
    end

    // PC and delay-slot pair, updated once per instruction.
    always_ff @(posedge clk) begin
        if (rst) begin
            pc      <= RESET_VECTOR;
            pc_next <= RESET_VECTOR + 32'd4;
        end else if (exec2_edge) begin
            pc      <= pc_next;
            pc_next <= res.taken ? res.target : pc_next + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b1;
        end else if (halt) begin
            active <= 1'b0;
        end
    end

    // Strobe for the core's register write.
    assign link_write    = res.link && !stall && state == mips_pc_pkg::EXEC2;
    assign link_data     = pc + 32'd8;
    assign link_dest_out = link_dest;

endmodule

// ==== logic/next_instruction_top.sv ====
`timescale 1ns/1ps

module next_instruction_top #(
    parameter mips_pc_pkg::addr_t RESET_VECTOR = mips_pc_pkg::DEFAULT_RESET_VECTOR
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [31:0]               instr,
    input  mips_pc_pkg::addr_t        r_s,
    input  mips_pc_pkg::addr_t        r_t,
    input  logic                      stall,
    output mips_pc_pkg::addr_t        pc,
    output mips_pc_pkg::cycle_state_e state,
    output logic                      active,
    output logic                      link_write,
    output mips_pc_pkg::addr_t        link_data,
    output logic [4:0]                link_dest
);

    mips_pc_pkg::branch_ctrl_t ctrl;
    mips_pc_pkg::resolve_t     res;
    mips_pc_pkg::addr_t        pc_next;

    branch_decode branch_decode_inst (
        .instr (instr),
        .ctrl  (ctrl)
    );

    branch_resolve branch_resolve_inst (
        .ctrl    (ctrl),
        .r_s     (r_s),
        .r_t     (r_t),
        .pc_next (pc_next),
        .res     (res)
    );

    pc_sequencer #(
        .RESET_VECTOR (RESET_VECTOR)
    ) pc_sequencer_inst (
        .clk           (clk),
        .rst           (rst),
        .stall         (stall),
        .res           (res),
        .link_dest     (ctrl.link_dest),
        .state         (state),
        .pc            (pc),
        .pc_next       (pc_next),
        .active        (active),
        .link_write    (link_write),
        .link_data     (link_data),
        .link_dest_out (link_dest)
    );

endmodule

// ==== sim/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;   // Released on a falling edge.
    end

endmodule

// ==== sim/next_instruction_assertions.sv ====
`timescale 1ns/1ps

module next_instruction_assertions (
    input logic        clk,
    input logic        rst,
    input logic        stall,
    input logic [1:0]  state,
    input logic [31:0] pc,
    input logic        active,
    input logic        link_write
);

    int failures = 0;

    state_legal: assert property (@(posedge clk) disable iff (rst) state != 2'b11) else begin
        failures++;
        $error("state holds the unused encoding");
    end

    link_in_exec2: assert property (
        @(posedge clk) disable iff (rst) link_write |-> state == mips_pc_pkg::EXEC2
    ) else begin
        failures++;
        $error("link_write high outside EXEC2");
    end

    // PC moves only when an unstalled EXEC2 ends.
    pc_update_point: assert property (
        @(posedge clk) disable iff (rst)
        !$stable(pc) |-> $past(state == mips_pc_pkg::EXEC2 && !stall)
    ) else begin
        failures++;
        $error("pc changed outside an unstalled EXEC2");
    end

    active_only_by_reset: assert property (@(posedge clk) $rose(active) |-> $past(rst)) else begin
        failures++;
        $error("active rose without reset");
    end

endmodule

// ==== sim/next_instruction_tb.sv ====
`timescale 1ns/1ps

module next_instruction_tb;

    typedef mips_pc_pkg::addr_t addr_t;

    localparam int    CLK_PERIOD_NS = 40;
    localparam int    RESET_CYCLES  = 10;
    localparam int    SETTLE_NS     = 10;
    localparam addr_t RESET_VECTOR  = 32'h0040_0000;
    localparam int    NUM_INSTR     = 64;
    localparam int    RUN_CYCLES    = RESET_CYCLES + 3 * NUM_INSTR + 6 + 4 + 4;
    localparam int    WATCHDOG_NS   = 2 * RUN_CYCLES * CLK_PERIOD_NS;

    localparam mips_pc_pkg::cycle_state_e PHASES [3] = '{
        mips_pc_pkg::FETCH, mips_pc_pkg::EXEC1, mips_pc_pkg::EXEC2
    };

    logic                      clk;
    logic                      rst;
    logic [31:0]               instr;
    addr_t                     r_s;
    addr_t                     r_t;
    logic                      stall;
    addr_t                     pc;
    mips_pc_pkg::cycle_state_e state;
    logic                      active;
    logic                      link_write;
    addr_t                     link_data;
    logic [4:0]                link_dest;

    addr_t       exp_pc;
    addr_t       exp_pc_next;   // Expected delay-slot address.
    logic [31:0] lfsr_state = 32'd99927;

    clock_gen #(
        .PERIOD_NS    (CLK_PERIOD_NS),
        .RESET_CYCLES (RESET_CYCLES)
    ) clock_gen_inst (
        .clk (clk),
        .rst (rst)
    );

    next_instruction_top #(
        .RESET_VECTOR (RESET_VECTOR)
    ) next_instruction_top_inst (
        .clk        (clk),
        .rst        (rst),
        .instr      (instr),
        .r_s        (r_s),
        .r_t        (r_t),
        .stall      (stall),
        .pc         (pc),
        .state      (state),
        .active     (active),
        .link_write (link_write),
        .link_data  (link_data),
        .link_dest  (link_dest)
    );

    bind pc_sequencer next_instruction_assertions seq_assertions_inst (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .state      (state),
        .pc         (pc),
        .active     (active),
        .link_write (link_write)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    task automatic random_bits(input int n, output addr_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR t=%0t %s: got %h, expected %h", $time, name, actual, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    function automatic logic [31:0] branch_word(input mips_pc_pkg::branch_kind_e kind,
                                                input logic [15:0] imm);
        case (kind)
            mips_pc_pkg::BEQ:    return {6'd4, 5'd8, 5'd9, imm};
            mips_pc_pkg::BNE:    return {6'd5, 5'd8, 5'd9, imm};
            mips_pc_pkg::BLEZ:   return {6'd6, 5'd8, 5'd0, imm};
            mips_pc_pkg::BGTZ:   return {6'd7, 5'd8, 5'd0, imm};
            mips_pc_pkg::BLTZ:   return {6'd1, 5'd8, 5'd0, imm};   // Condition sits in rt.
            mips_pc_pkg::BGEZ:   return {6'd1, 5'd8, 5'd1, imm};
            mips_pc_pkg::BLTZAL: return {6'd1, 5'd8, 5'd16, imm};
            default:             return {6'd1, 5'd8, 5'd17, imm};
        endcase
    endfunction

    function automatic logic branch_taken(input mips_pc_pkg::branch_kind_e kind,
                                          input addr_t rs_val, input addr_t rt_val);
        case (kind)
            mips_pc_pkg::BEQ:  return rs_val == rt_val;
            mips_pc_pkg::BNE:  return rs_val != rt_val;
            mips_pc_pkg::BLEZ: return $signed(rs_val) <= 0;
            mips_pc_pkg::BGTZ: return $signed(rs_val) > 0;
            mips_pc_pkg::BLTZ,
            mips_pc_pkg::BLTZAL: return $signed(rs_val) < 0;
            default:           return $signed(rs_val) >= 0;   // BGEZ and BGEZAL.
        endcase
    endfunction

    task automatic advance_model(input logic taken, input addr_t target);
        exp_pc      = exp_pc_next;
        exp_pc_next = taken ? target : exp_pc_next + 32'd4;
    endtask

    // Enters and leaves on a falling edge in FETCH.
    task automatic issue_instr(input logic [31:0] word, input addr_t rs_val, input addr_t rt_val,
                               input logic taken, input addr_t target, input logic link,
                               input logic [4:0] dest);
        instr = word;
        r_s   = rs_val;
        r_t   = rt_val;
        stall = 1'b0;
        for (int ph = 0; ph < 3; ph++) begin
            #(SETTLE_NS);
            check_value("state", state, PHASES[ph]);
            check_value("pc", pc, exp_pc);
            check_value("link_write", link_write, (ph == 2) && link);
            if (ph == 2 && link) begin
                check_value("link_data", link_data, exp_pc + 32'd8);
                check_value("link_dest", link_dest, dest);
            end
            @(negedge clk);
        end
        advance_model(taken, target);
    endtask

    task automatic issue_nop();
        issue_instr(32'h0000_0000, '0, '0, 1'b0, '0, 1'b0, 5'd0);
    endtask

    task automatic test_reset_sequence();
        check_value("pc", pc, RESET_VECTOR);
        check_value("state", state, mips_pc_pkg::FETCH);
        check_value("active", active, 1'b1);
        check_value("link_write", link_write, 1'b0);
        exp_pc      = RESET_VECTOR;
        exp_pc_next = RESET_VECTOR + 32'd4;
        repeat (4) issue_nop();
    endtask

    task automatic run_jump(input logic [31:0] word, input addr_t rs_val, input addr_t target,
                            input logic link, input logic [4:0] dest);
        issue_instr(word, rs_val, '0, 1'b1, target, link, dest);
        issue_nop();   // Delay slot.
        check_value("pc", pc, target);
    endtask

    task automatic test_jumps();
        run_jump({6'd2, 26'h3F0_0040}, '0, {exp_pc_next[31:28], 26'h3F0_0040, 2'b00}, 1'b0, 5'd0);
        run_jump({6'd3, 26'h3F0_0080}, '0, {exp_pc_next[31:28], 26'h3F0_0080, 2'b00}, 1'b1, 5'd31);
        run_jump({6'd0, 5'd4, 15'd0, 6'd8}, 32'hBFC0_1000, 32'hBFC0_1000, 1'b0, 5'd0);
        run_jump({6'd0, 5'd5, 5'd0, 5'd7, 5'd0, 6'd9}, 32'hBFC0_2000, 32'hBFC0_2000, 1'b1, 5'd7);
    endtask

    task automatic run_branch(input mips_pc_pkg::branch_kind_e kind, input addr_t rs_val,
                              input addr_t rt_val);
        addr_t bits;
        addr_t slot;
        addr_t target;
        logic  taken;
        logic  link;
        random_bits(16, bits);
        slot   = exp_pc_next;
        target = slot + {{14{bits[15]}}, bits[15:0], 2'b00};
        taken  = branch_taken(kind, rs_val, rt_val);
        link   = kind inside {mips_pc_pkg::BLTZAL, mips_pc_pkg::BGEZAL};
        issue_instr(branch_word(kind, bits[15:0]), rs_val, rt_val, taken, target, link, 5'd31);
        issue_nop();
        check_value("pc", pc, taken ? target : slot + 32'd4);
    endtask

    task automatic test_branches();
        mips_pc_pkg::branch_kind_e kinds [8];
        addr_t a;
        addr_t b;
        kinds = '{mips_pc_pkg::BEQ, mips_pc_pkg::BNE, mips_pc_pkg::BLEZ, mips_pc_pkg::BGTZ,
                  mips_pc_pkg::BLTZ, mips_pc_pkg::BGEZ, mips_pc_pkg::BLTZAL, mips_pc_pkg::BGEZAL};
        foreach (kinds[k]) begin
            random_bits(32, a);
            random_bits(32, b);
            run_branch(kinds[k], a, b);
            run_branch(kinds[k], '0, '0);
            random_bits(32, a);
            run_branch(kinds[k], a | 32'h8000_0000, b);   // Negative r_s.
        end
    endtask

    task automatic test_stall();
        addr_t neg_rs;
        random_bits(32, neg_rs);
        neg_rs[31] = 1'b1;
        instr = branch_word(mips_pc_pkg::BGEZAL, 16'h0010);   // Not taken but links.
        r_s   = neg_rs;
        r_t   = '0;
        for (int ph = 0; ph < 3; ph++) begin
            stall = 1'b1;
            repeat (2) begin
                #(SETTLE_NS);
                check_value("state", state, PHASES[ph]);
                check_value("pc", pc, exp_pc);
                check_value("link_write", link_write, 1'b0);
                @(negedge clk);
            end
            stall = 1'b0;
            #(SETTLE_NS);
            check_value("state", state, PHASES[ph]);
            check_value("link_write", link_write, ph == 2);
            @(negedge clk);
        end
        advance_model(1'b0, '0);
        issue_nop();
    endtask

    task automatic test_halt();
        issue_instr({6'd0, 5'd4, 15'd0, 6'd8}, '0, '0, 1'b1, '0, 1'b0, 5'd0);
        issue_nop();
        check_value("pc", pc, 32'd0);
        repeat (4) begin
            @(negedge clk);
            check_value("active", active, 1'b0);
            check_value("state", state, mips_pc_pkg::FETCH);
            check_value("pc", pc, 32'd0);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests completed");
        $display("TESTBENCH FAILED");
        $fatal(1, "Timeout");
    end

    // Stops the run at the first concurrent assertion failure.
    initial begin
        wait (next_instruction_top_inst.pc_sequencer_inst.seq_assertions_inst.failures != 0);
        $display("A concurrent assertion on the sequencer failed");
        $display("TESTBENCH FAILED");
        $fatal(1, "Assertion failure");
    end

    initial begin
        instr = '0;
        r_s   = '0;
        r_t   = '0;
        stall = 1'b1;   // Hold the DUT until the first test.
        @(negedge clk);
        while (rst) @(negedge clk);
        @(negedge clk);
        test_reset_sequence();
        test_jumps();
        test_branches();
        test_stall();
        test_halt();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== filelist.f ====
logic/mips_pc_pkg.sv
logic/branch_decode.sv
logic/branch_resolve.sv
logic/pc_sequencer.sv
logic/next_instruction_top.sv
sim/clock_gen.sv
sim/next_instruction_assertions.sv
sim/next_instruction_tb.sv
